// File: cache_cfg_pkg.sv
package cache_cfg_pkg;

    // cpu and memory word geometry
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    // byte offset inside a word, ignored by the cache
    localparam int OFFSET_W = 2;
    // associativity, tied to the 3-bit plru tree
    localparam int NUM_WAYS = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // request from the cpu side, held until mem_resp
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    // request toward backing memory, held until pmem_resp
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

// File: cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // controller states
    // LOOKUP answers hits, the others sequence misses and the buffer
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WRITE,
        EVICT,
        DRAIN
    } ctrl_state_t;

    // one bit per way
    typedef logic [cache_cfg_pkg::NUM_WAYS-1:0] way_oh_t;

    // write command for the tag and data arrays
    typedef struct packed {
        // ways to write, usually one-hot
        way_oh_t way;
        // take the tag from the request, else keep the stored tag
        logic    load_tag;
        logic    valid_in;
        logic    dirty_in;
        // also write the data word
        logic    load_data;
    } way_write_t;

endpackage

// File: set_array.sv
module set_array #(
    parameter int  NUM_SETS = 8,
    parameter type entry_t  = logic
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(NUM_SETS)-1:0] index,
    input  logic                        we,
    input  entry_t                      wdata,
    output entry_t                      rdata
);

    // one entry per set
    entry_t entries [NUM_SETS];

    // read is combinational at the current index
    assign rdata = entries[index];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // everything starts invalid and clean
            entries <= '{default: '0};
        end
        else if (we)
        begin
            entries[index] <= wdata;
        end
    end

endmodule

// File: plru_tree.sv
module plru_tree #(
    parameter int NUM_SETS = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(NUM_SETS)-1:0] index,
    input  logic                        update,
    input  cache_ctrl_pkg::way_oh_t     used_way,
    output cache_ctrl_pkg::way_oh_t     victim_way
);

    // three tree bits per set
    // bit 2 picks the half, bit 1 the left pair, bit 0 the right pair
    logic [2:0] tree [NUM_SETS];
    logic [2:0] bits;

    assign bits = tree[index];

    // walk the tree toward the least recently used side
    always_comb
    begin
        if (bits[2])
        begin
            victim_way = bits[1] ? 4'b0001 : 4'b0010;
        end
        else
        begin
            victim_way = bits[0] ? 4'b0100 : 4'b1000;
        end
    end

    // point the tree away from the way just used
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tree <= '{default: '0};
        end
        else if (update)
        begin
            case (used_way)
                4'b0001: tree[index][2:1] <= 2'b00;
                4'b0010: tree[index][2:1] <= 2'b01;
                4'b0100: {tree[index][2], tree[index][0]} <= 2'b10;
                4'b1000: {tree[index][2], tree[index][0]} <= 2'b11;
                // no single way, leave the tree alone
                default: ;
            endcase
        end
    end

endmodule

// File: evict_buffer.sv
module evict_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  cache_cfg_pkg::addr_t load_addr,
    input  cache_cfg_pkg::word_t load_data,
    input  logic                 pop,
    input  cache_cfg_pkg::addr_t lookup_addr,
    input  logic                 cpu_write,
    input  cache_cfg_pkg::word_t cpu_wdata,
    output logic                 buf_hit,
    output logic                 buf_empty,
    output cache_cfg_pkg::addr_t buf_addr,
    output cache_cfg_pkg::word_t buf_data
);

    import cache_cfg_pkg::*;

    logic  valid;
    addr_t addr_q;
    word_t data_q;

    // match on the word address, byte offset ignored
    assign buf_hit   = valid && (lookup_addr[ADDR_W-1:OFFSET_W] == addr_q[ADDR_W-1:OFFSET_W]);
    assign buf_empty = !valid;
    assign buf_addr  = addr_q;
    assign buf_data  = data_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid <= 1'b0;
        end
        else if (load)
        begin
            valid <= 1'b1;
        end
        else if (pop)
        begin
            valid <= 1'b0;
        end
    end

    // payload of the held line
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            addr_q <= load_addr;
            data_q <= load_data;
        end
        else if (cpu_write && buf_hit)
        begin
            // cpu store to the evicted word lands here
            data_q <= cpu_wdata;
        end
    end

endmodule

// File: cache_datapath.sv
module cache_datapath #(
    parameter int NUM_SETS = 8
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  cache_cfg_pkg::addr_t                   addr,
    input  cache_cfg_pkg::word_t                   cpu_wdata,
    input  cache_cfg_pkg::word_t                   refill_data,
    input  cache_ctrl_pkg::way_write_t             way_wr,
    input  logic                                   cpu_write_hit,
    output logic                                   hit,
    output cache_ctrl_pkg::way_oh_t                hit_way,
    output logic [cache_cfg_pkg::NUM_WAYS-1:0]     valid_vec,
    output logic [cache_cfg_pkg::NUM_WAYS-1:0]     dirty_vec,
    input  cache_ctrl_pkg::way_oh_t                rd_way,
    output cache_cfg_pkg::word_t                   way_data,
    output cache_cfg_pkg::addr_t                   victim_addr
);

    import cache_cfg_pkg::*;

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    // per-way tag state, one of these per set
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    logic [IDX_W-1:0] index;
    logic [TAG_W-1:0] tag;
    tag_entry_t       entry_rd [NUM_WAYS];
    word_t            word_rd  [NUM_WAYS];
    word_t            word_wr;
    word_t            refill_q;

    // address split: tag | index | byte offset
    assign index = addr[OFFSET_W +: IDX_W];
    assign tag   = addr[ADDR_W-1 -: TAG_W];

    // memory data is only valid in the pmem_resp cycle
    // so REFILL_WRITE uses the copy from one cycle back
    always_ff @(posedge clk)
    begin
        refill_q <= refill_data;
    end

    // store data from the cpu on a write hit, else refill data
    assign word_wr = cpu_write_hit ? cpu_wdata : refill_q;

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        tag_entry_t entry_wr;

        // invalidate keeps the old tag, refill and store take the new one
        always_comb
        begin
            entry_wr.valid = way_wr.valid_in;
            entry_wr.dirty = way_wr.dirty_in;
            entry_wr.tag   = way_wr.load_tag ? tag : entry_rd[w].tag;
        end

        set_array #(
            .NUM_SETS (NUM_SETS),
            .entry_t  (tag_entry_t)
        ) u_tags (
            .clk   (clk),
            .rst   (rst),
            .index (index),
            .we    (way_wr.way[w]),
            .wdata (entry_wr),
            .rdata (entry_rd[w])
        );

        set_array #(
            .NUM_SETS (NUM_SETS),
            .entry_t  (word_t)
        ) u_data (
            .clk   (clk),
            .rst   (rst),
            .index (index),
            .we    (way_wr.way[w] & way_wr.load_data),
            .wdata (word_wr),
            .rdata (word_rd[w])
        );

        // tag compare
        assign hit_way[w]   = entry_rd[w].valid && (entry_rd[w].tag == tag);
        assign valid_vec[w] = entry_rd[w].valid;
        assign dirty_vec[w] = entry_rd[w].dirty;
    end

    assign hit = |hit_way;

    // one-hot read mux, also rebuilds the word address of that way
    always_comb
    begin
        way_data    = '0;
        victim_addr = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (rd_way[w])
            begin
                way_data    = word_rd[w];
                victim_addr = {entry_rd[w].tag, index, {OFFSET_W{1'b0}}};
            end
        end
    end

endmodule

// File: cache_control.sv
module cache_control #(
    parameter int MISS_CNT_W = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               read,
    input  logic                               write,
    input  logic                               hit,
    input  cache_ctrl_pkg::way_oh_t            hit_way,
    input  logic [cache_cfg_pkg::NUM_WAYS-1:0] valid_vec,
    input  logic [cache_cfg_pkg::NUM_WAYS-1:0] dirty_vec,
    input  cache_ctrl_pkg::way_oh_t            victim_way,
    input  logic                               buf_hit,
    input  logic                               buf_empty,
    input  logic                               pmem_resp,
    output logic                               mem_resp,
    output logic                               pmem_read,
    output logic                               pmem_write,
    output logic                               use_buf_addr,
    output cache_ctrl_pkg::way_write_t         way_wr,
    output logic                               cpu_write_hit,
    output cache_ctrl_pkg::way_oh_t            rd_way,
    output logic                               plru_update,
    output logic                               evict_load,
    output logic                               drain_pop,
    output logic [MISS_CNT_W-1:0]              miss_count
);

    import cache_cfg_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_t           state;
    ctrl_state_t           next_state;
    way_oh_t               fill_way;
    logic                  fill_dirty;
    logic                  miss_inc;
    logic [MISS_CNT_W-1:0] miss_q;

    // refill target: lowest invalid way, else the plru victim
    // stays stable through EVICT and refill since the victim turns invalid
    always_comb
    begin
        fill_way = victim_way;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_vec[w])
            begin
                fill_way = way_oh_t'(1 << w);
            end
        end
    end

    assign fill_dirty = |(fill_way & valid_vec & dirty_vec);

    always_comb
    begin
        next_state    = state;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        use_buf_addr  = 1'b0;
        way_wr        = '0;
        cpu_write_hit = 1'b0;
        rd_way        = hit_way;
        plru_update   = 1'b0;
        evict_load    = 1'b0;
        drain_pop     = 1'b0;
        miss_inc      = 1'b0;

        case (state)
            IDLE:
            begin
                // cpu first, drain only when nothing is asked
                if (read || write)
                begin
                    next_state = LOOKUP;
                end
                else if (!buf_empty)
                begin
                    next_state = DRAIN;
                end
            end

            LOOKUP:
            begin
                if (hit || buf_hit)
                begin
                    mem_resp      = 1'b1;
                    plru_update   = hit;
                    // a store goes to whichever copy matched
                    cpu_write_hit = write;
                    if (write && hit)
                    begin
                        way_wr = '{way: hit_way, load_tag: 1'b1, valid_in: 1'b1,
                                   dirty_in: 1'b1, load_data: 1'b1};
                    end
                    next_state = IDLE;
                end
                else if (!fill_dirty)
                begin
                    miss_inc   = 1'b1;
                    next_state = REFILL_REQ;
                end
                else if (buf_empty)
                begin
                    miss_inc   = 1'b1;
                    next_state = EVICT;
                end
                else
                begin
                    // buffer still busy, empty it and retry from IDLE
                    next_state = DRAIN;
                end
            end

            EVICT:
            begin
                // victim word into the buffer, way marked invalid
                rd_way     = fill_way;
                evict_load = 1'b1;
                way_wr     = '{way: fill_way, load_tag: 1'b0, valid_in: 1'b0,
                               dirty_in: 1'b0, load_data: 1'b0};
                next_state = REFILL_REQ;
            end

            REFILL_REQ:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    next_state = REFILL_WRITE;
                end
            end

            REFILL_WRITE:
            begin
                // clean copy, the LOOKUP after this hits
                way_wr     = '{way: fill_way, load_tag: 1'b1, valid_in: 1'b1,
                               dirty_in: 1'b0, load_data: 1'b1};
                next_state = LOOKUP;
            end

            DRAIN:
            begin
                pmem_write   = 1'b1;
                use_buf_addr = 1'b1;
                if (pmem_resp)
                begin
                    drain_pop  = 1'b1;
                    next_state = IDLE;
                end
            end

            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // miss counter, sticks at all ones
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            miss_q <= '0;
        end
        else if (miss_inc && (miss_q != '1))
        begin
            miss_q <= miss_q + 1'b1;
        end
    end

    assign miss_count = miss_q;

endmodule

// File: l2_cache.sv
module l2_cache #(
    parameter int NUM_SETS   = 8,
    parameter int MISS_CNT_W = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_cfg_pkg::cpu_req_t req,
    output logic                    mem_resp,
    output cache_cfg_pkg::word_t    rdata,
    output cache_cfg_pkg::mem_req_t pmem_req,
    input  logic                    pmem_resp,
    input  cache_cfg_pkg::word_t    pmem_rdata,
    output logic [MISS_CNT_W-1:0]   miss_count
);

    import cache_cfg_pkg::*;
    import cache_ctrl_pkg::*;

    logic                    hit;
    way_oh_t                 hit_way;
    logic [NUM_WAYS-1:0]     valid_vec;
    logic [NUM_WAYS-1:0]     dirty_vec;
    way_oh_t                 victim_way;
    way_oh_t                 rd_way;
    way_write_t              way_wr;
    logic                    cpu_write_hit;
    logic                    plru_update;
    logic                    evict_load;
    logic                    drain_pop;
    logic                    use_buf_addr;
    logic                    pmem_read;
    logic                    pmem_write;
    logic                    buf_hit;
    logic                    buf_empty;
    addr_t                   buf_addr;
    word_t                   buf_data;
    word_t                   way_data;
    addr_t                   victim_addr;
    logic [$clog2(NUM_SETS)-1:0] index;

    assign index = req.addr[OFFSET_W +: $clog2(NUM_SETS)];

    // buffered copy wins when it matches
    assign rdata = buf_hit ? buf_data : way_data;

    // memory side: refill reads the request word, drain writes the buffer
    assign pmem_req.read  = pmem_read;
    assign pmem_req.write = pmem_write;
    assign pmem_req.addr  = use_buf_addr ? buf_addr
                                         : {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign pmem_req.wdata = buf_data;

    cache_control #(.MISS_CNT_W(MISS_CNT_W)) u_control (
        .clk(clk), .rst(rst), .read(req.read), .write(req.write),
        .hit(hit), .hit_way(hit_way), .valid_vec(valid_vec), .dirty_vec(dirty_vec),
        .victim_way(victim_way), .buf_hit(buf_hit), .buf_empty(buf_empty),
        .pmem_resp(pmem_resp), .mem_resp(mem_resp), .pmem_read(pmem_read),
        .pmem_write(pmem_write), .use_buf_addr(use_buf_addr), .way_wr(way_wr),
        .cpu_write_hit(cpu_write_hit), .rd_way(rd_way), .plru_update(plru_update),
        .evict_load(evict_load), .drain_pop(drain_pop), .miss_count(miss_count)
    );

    cache_datapath #(.NUM_SETS(NUM_SETS)) u_datapath (
        .clk(clk), .rst(rst), .addr(req.addr), .cpu_wdata(req.wdata),
        .refill_data(pmem_rdata), .way_wr(way_wr), .cpu_write_hit(cpu_write_hit),
        .hit(hit), .hit_way(hit_way), .valid_vec(valid_vec), .dirty_vec(dirty_vec),
        .rd_way(rd_way), .way_data(way_data), .victim_addr(victim_addr)
    );

    // replacement state follows cache hits only
    plru_tree #(.NUM_SETS(NUM_SETS)) u_plru (
        .clk(clk), .rst(rst), .index(index), .update(plru_update),
        .used_way(hit_way), .victim_way(victim_way)
    );

    evict_buffer u_evict (
        .clk(clk), .rst(rst), .load(evict_load), .load_addr(victim_addr),
        .load_data(way_data), .pop(drain_pop), .lookup_addr(req.addr),
        .cpu_write(cpu_write_hit), .cpu_wdata(req.wdata), .buf_hit(buf_hit),
        .buf_empty(buf_empty), .buf_addr(buf_addr), .buf_data(buf_data)
    );

endmodule

// File: tb_mem_model.sv
module tb_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_cfg_pkg::mem_req_t pmem_req,
    output logic                    pmem_resp,
    output cache_cfg_pkg::word_t    pmem_rdata,
    input  cache_cfg_pkg::addr_t    peek_addr,
    output cache_cfg_pkg::word_t    peek_data
);

    timeunit 1ns;
    timeprecision 1ps;

    import cache_cfg_pkg::*;

    localparam int    RESP_DELAY = 3;
    localparam int    DRIVE_DLY  = 2;
    localparam word_t FILL_KEY   = 32'hA5A5A5A5;

    // only written words are stored, the rest follow the fill pattern
    word_t mem [addr_t];
    int    wait_cnt;

    function word_t read_word(input addr_t a);
        if (mem.exists(a))
        begin
            return mem[a];
        end
        return a ^ FILL_KEY;
    endfunction

    initial
    begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        peek_data  = '0;
        wait_cnt   = 0;
        forever
        begin
            @(posedge clk);
            #(DRIVE_DLY);
            // response is a one-cycle pulse
            pmem_resp = 1'b0;
            if (rst || !(pmem_req.read || pmem_req.write))
            begin
                wait_cnt = 0;
            end
            else
            begin
                wait_cnt++;
                if (wait_cnt == RESP_DELAY)
                begin
                    pmem_resp = 1'b1;
                    if (pmem_req.write)
                    begin
                        mem[pmem_req.addr] = pmem_req.wdata;
                    end
                    else
                    begin
                        pmem_rdata = read_word(pmem_req.addr);
                    end
                    wait_cnt = 0;
                end
            end
            // debug view of the stored word
            peek_data = read_word(peek_addr);
        end
    end

endmodule

// File: tb_l2_cache.sv
module tb_l2_cache;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_cfg_pkg::*;

    localparam int          HALF_PERIOD     = 20;
    localparam int          CLK_PERIOD      = 2 * HALF_PERIOD;
    localparam int          DRIVE_DLY       = 2;
    localparam int          RESET_CYCLES    = 16;
    localparam int          NUM_TESTS       = 6;
    localparam int          CYCLES_PER_TEST = 200;
    localparam int          MISS_CNT_W      = 16;
    localparam logic [31:0] RNG_SEED        = 32'h1952ac4a;
    localparam word_t       FILL_KEY        = 32'hA5A5A5A5;
    // set 1 for the simple tests
    localparam addr_t       ADDR_SIMPLE     = 32'h0000_1004;
    // five tags that all fall in set 3
    localparam addr_t       ADDR_A          = 32'h0001_000C;
    localparam addr_t       ADDR_B          = 32'h0002_000C;
    localparam addr_t       ADDR_C          = 32'h0003_000C;
    localparam addr_t       ADDR_D          = 32'h0004_000C;
    localparam addr_t       ADDR_E          = 32'h0005_000C;

    logic                  clk;
    logic                  rst;
    cpu_req_t              req;
    logic                  mem_resp;
    word_t                 rdata;
    mem_req_t              pmem_req;
    logic                  pmem_resp;
    word_t                 pmem_rdata;
    logic [MISS_CNT_W-1:0] miss_count;
    addr_t                 peek_addr;
    word_t                 peek_data;
    int                    exp_misses;
    word_t                 a_data;
    int                    drain_count = 0;
    addr_t                 drain_addr;
    word_t                 drain_data;

    l2_cache dut (
        .clk(clk), .rst(rst), .req(req), .mem_resp(mem_resp), .rdata(rdata),
        .pmem_req(pmem_req), .pmem_resp(pmem_resp), .pmem_rdata(pmem_rdata),
        .miss_count(miss_count)
    );

    tb_mem_model mem_model (
        .clk(clk), .rst(rst), .pmem_req(pmem_req), .pmem_resp(pmem_resp),
        .pmem_rdata(pmem_rdata), .peek_addr(peek_addr), .peek_data(peek_data)
    );

    always #(HALF_PERIOD) clk = ~clk;

    // every completed memory write
    always @(negedge clk)
    begin
        if (pmem_req.write && pmem_resp)
        begin
            drain_count++;
            drain_addr = pmem_req.addr;
            drain_data = pmem_req.wdata;
        end
    end

    initial
    begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        report_failure("timeout, the tests did not finish in time");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic require(input logic cond, input string msg);
        assert (cond)
        else report_failure(msg);
    endtask

    // backing memory contents before any write
    function automatic word_t fill_word(input addr_t a);
        return a ^ FILL_KEY;
    endfunction

    // one cpu request held until mem_resp
    // starts and ends just after a rising edge
    task automatic cpu_access(input logic is_write, input addr_t addr, input word_t wdata,
                              output word_t data, output int cycles, output int busy);
        cycles = 0;
        busy   = 0;
        req    = '{read: !is_write, write: is_write, addr: addr, wdata: wdata};
        do
        begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (pmem_req.read || pmem_req.write)
            begin
                busy++;
            end
        end
        while (!mem_resp);
        data = rdata;
        @(posedge clk);
        #(DRIVE_DLY);
        req = '0;
    endtask

    task automatic check_quiet_outputs();
        compare_value("mem_resp", 32'(mem_resp), 32'h0);
        compare_value("pmem_req.read", 32'(pmem_req.read), 32'h0);
        compare_value("pmem_req.write", 32'(pmem_req.write), 32'h0);
        compare_value("miss_count", 32'(miss_count), 32'h0);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES - 1)
        begin
            @(posedge clk);
            @(negedge clk);
            check_quiet_outputs();
        end
        @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;
        // no request and an empty buffer keep the controller idle
        repeat (4)
        begin
            @(negedge clk);
            check_quiet_outputs();
        end
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic read_miss_then_hit();
        word_t data;
        int    cycles;
        int    busy;
        cpu_access(1'b0, ADDR_SIMPLE, '0, data, cycles, busy);
        compare_value("rdata", data, fill_word(ADDR_SIMPLE));
        require(busy > 0, "read miss made no memory request");
        exp_misses += 1;
        compare_value("miss_count", 32'(miss_count), 32'(exp_misses));
        // same word again is now a hit
        cpu_access(1'b0, ADDR_SIMPLE, '0, data, cycles, busy);
        compare_value("rdata", data, fill_word(ADDR_SIMPLE));
        require(cycles == 1, "read hit did not answer one cycle after the request");
        require(busy == 0, "read hit touched memory");
        compare_value("miss_count", 32'(miss_count), 32'(exp_misses));
    endtask

    task automatic write_hit_read_back();
        word_t wdata;
        word_t data;
        int    cycles;
        int    busy;
        wdata = $urandom();
        cpu_access(1'b1, ADDR_SIMPLE, wdata, data, cycles, busy);
        require(cycles == 1, "write hit did not answer one cycle after the request");
        require(busy == 0, "write hit touched memory");
        cpu_access(1'b0, ADDR_SIMPLE, '0, data, cycles, busy);
        compare_value("rdata", data, wdata);
        require(cycles == 1, "read after write hit was not a hit");
        require(busy == 0, "read after write hit touched memory");
        compare_value("miss_count", 32'(miss_count), 32'(exp_misses));
    endtask

    // plru trace in set 3 with tree bits {2,1,0}
    // fills A..D into ways 0..3 and the tree ends at 111
    // write A gives 001 and reads of B C D give 011 110 111
    // E then follows set bits 2 and 1 down to way 0 (A)
    task automatic plru_victim_eviction();
        addr_t fill_addrs [4];
        word_t data;
        int    cycles;
        int    busy;
        int    writes_before;
        fill_addrs = '{ADDR_A, ADDR_B, ADDR_C, ADDR_D};
        for (int i = 0; i < 4; i++)
        begin
            cpu_access(1'b0, fill_addrs[i], '0, data, cycles, busy);
            compare_value("rdata", data, fill_word(fill_addrs[i]));
            require(busy > 0, "first read of a set address made no memory request");
            exp_misses += 1;
        end
        a_data = $urandom();
        cpu_access(1'b1, ADDR_A, a_data, data, cycles, busy);
        require(cycles == 1 && busy == 0, "write to A was not a hit");
        for (int i = 1; i < 4; i++)
        begin
            cpu_access(1'b0, fill_addrs[i], '0, data, cycles, busy);
            compare_value("rdata", data, fill_word(fill_addrs[i]));
            require(cycles == 1 && busy == 0, "re-read in set 3 was not a hit");
        end
        writes_before = drain_count;
        cpu_access(1'b0, ADDR_E, '0, data, cycles, busy);
        compare_value("rdata", data, fill_word(ADDR_E));
        require(busy > 0, "read of E made no memory request");
        exp_misses += 1;
        // victim sits in the buffer and is not yet written back
        require(drain_count == writes_before, "memory written before the buffer drained");
        compare_value("miss_count", 32'(miss_count), 32'(exp_misses));
    endtask

    task automatic buffer_read_and_drain();
        word_t data;
        int    cycles;
        int    busy;
        int    writes_before;
        writes_before = drain_count;
        // back to back with E the request beats the drain in IDLE
        cpu_access(1'b0, ADDR_A, '0, data, cycles, busy);
        compare_value("rdata", data, a_data);
        require(cycles == 1, "read of the buffered word was not a hit");
        // drop the request and let the buffer drain
        do
        begin
            @(posedge clk);
        end
        while (drain_count == writes_before);
        compare_value("pmem_req.addr", drain_addr, ADDR_A);
        compare_value("pmem_req.wdata", drain_data, a_data);
        @(posedge clk);
        #(DRIVE_DLY);
        peek_addr = ADDR_A;
        repeat (2)
        begin
            @(negedge clk);
            require(!pmem_req.read && !pmem_req.write, "memory busy after the drain");
            require(!mem_resp, "mem_resp high with no request");
        end
        compare_value("peek_data", peek_data, a_data);
        require(drain_count == writes_before + 1, "more than one memory write for A");
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic miss_count_total();
        // one miss in set 1 plus four fills and E in set 3
        compare_value("miss_count", 32'(miss_count), 32'(exp_misses));
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        peek_addr  = '0;
        exp_misses = 0;
        a_data     = '0;
        void'($urandom(RNG_SEED));
        apply_reset();
        read_miss_then_hit();
        write_hit_read_back();
        plru_victim_eviction();
        buffer_read_and_drain();
        miss_count_total();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: sources.f
cache_cfg_pkg.sv
cache_ctrl_pkg.sv
set_array.sv
plru_tree.sv
evict_buffer.sv
cache_datapath.sv
cache_control.sv
l2_cache.sv
tb_mem_model.sv
tb_l2_cache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_l2_cache -f sources.f -o tb_l2_cache
./obj_dir/tb_l2_cache
